//--- fm_defs.svh
`ifndef FM_DEFS_SVH
`define FM_DEFS_SVH

// Raw I/Q sample width as it arrives in the byte stream
`define FM_SAMPLE_BITS 16

// Working width of quantized samples and filter outputs
`define FM_DATA_BITS 32

// Fixed point shift for quantize and dequantize
`define FM_QUANT_BITS 10

// Channel filter length
`define FM_FIR_TAPS 20

`define FM_IN_FIFO_DEPTH 16
`define FM_OUT_FIFO_DEPTH 16

`endif

//--- fm_sample_pkg.sv
`default_nettype none

`include "fm_defs.svh"

package fm_sample_pkg;

    // One byte of the interleaved input stream
    typedef logic [7:0] byte_t;

    // Quantized sample
    typedef logic signed [`FM_DATA_BITS-1:0] sample_t;

    // Full product sums, wide enough that no tap sum overflows
    typedef logic signed [2*`FM_DATA_BITS-1:0] acc_t;

    typedef struct packed {
        sample_t i;
        sample_t q;
    } iq_t;

    typedef enum logic [1:0] {
        FIR_IDLE,
        FIR_ACCUMULATE,
        FIR_WRITE
    } fir_state_t;

endpackage

`default_nettype wire

//--- fm_coeff_pkg.sv
`default_nettype none

`include "fm_defs.svh"

package fm_coeff_pkg;

    typedef logic signed [`FM_DATA_BITS-1:0] coeff_t;

    // Channel low-pass, symmetric about the middle two taps
    localparam coeff_t CHANNEL_COEFFS [`FM_FIR_TAPS] = '{
        32'h00000001,
        32'h00000008,
        32'hfffffff3,
        32'h00000009,
        32'h0000000b,
        32'hffffffd3,
        32'h00000045,
        32'hffffffd3,
        32'hffffff31,
        32'h00000257,
        32'h00000257,
        32'hffffff31,
        32'hffffffd3,
        32'h00000045,
        32'hffffffd3,
        32'h0000000b,
        32'h00000009,
        32'hfffffff3,
        32'h00000008,
        32'h00000001
    };

endpackage

`default_nettype wire

//--- sample_fifo.sv
`default_nettype none

module sample_fifo #(
    parameter int unsigned WIDTH = 8,
    parameter int unsigned DEPTH = 16
) (
    input  logic             clock,
    input  logic             i_rst_n,
    input  logic             i_wr_en,
    input  logic [WIDTH-1:0] i_din,
    output logic             o_full,
    input  logic             i_rd_en,
    output logic [WIDTH-1:0] o_dout,
    output logic             o_empty
);

    localparam int unsigned PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_BITS = $clog2(DEPTH + 1);
    localparam logic [PTR_BITS-1:0] LAST_PTR = PTR_BITS'(DEPTH - 1);
    localparam logic [CNT_BITS-1:0] FULL_CNT = CNT_BITS'(DEPTH);

    logic [WIDTH-1:0]    mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic                wr_ok;
    logic                rd_ok;

    // Blocked accesses are dropped here
    assign wr_ok = i_wr_en && !o_full;
    assign rd_ok = i_rd_en && !o_empty;

    assign o_full  = (count == FULL_CNT);
    assign o_empty = (count == '0);

    // Show-ahead read
    assign o_dout = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (wr_ok) begin
            mem[wr_ptr] <= i_din;
        end
    end

    always_ff @(posedge clock) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- iq_decode.sv
`default_nettype none

`include "fm_defs.svh"

module iq_decode (
    input  logic                clock,
    input  logic                i_rst_n,
    input  fm_sample_pkg::byte_t i_byte,
    input  logic                i_byte_empty,
    output logic                o_byte_rd_en,
    input  logic                i_busy,
    output fm_sample_pkg::iq_t  o_sample,
    output logic                o_sample_wr_en
);

    logic [1:0]           byte_cnt;
    logic                 sample_valid;
    fm_sample_pkg::byte_t i_lo;
    fm_sample_pkg::byte_t i_hi;
    fm_sample_pkg::byte_t q_lo;

    // Sign-extend to the working width, then scale up
    function automatic fm_sample_pkg::sample_t quantize(
        input logic [`FM_SAMPLE_BITS-1:0] raw
    );
        fm_sample_pkg::sample_t ext;
        ext = {{(`FM_DATA_BITS - `FM_SAMPLE_BITS){raw[`FM_SAMPLE_BITS-1]}}, raw};
        return ext <<< `FM_QUANT_BITS;
    endfunction

    // No popping while a finished sample waits for the filter
    assign o_byte_rd_en   = !i_byte_empty && !sample_valid;
    assign o_sample_wr_en = sample_valid && !i_busy;

    always_ff @(posedge clock) begin
        if (!i_rst_n) begin
            byte_cnt     <= 2'd0;
            sample_valid <= 1'b0;
        end else begin
            if (o_byte_rd_en) begin
                byte_cnt <= byte_cnt + 2'd1;
            end
            if (o_byte_rd_en && byte_cnt == 2'd3) begin
                sample_valid <= 1'b1;
            end else if (o_sample_wr_en) begin
                sample_valid <= 1'b0;
            end
        end
    end

    // Byte order is I low, I high, Q low, Q high
    always_ff @(posedge clock) begin
        if (o_byte_rd_en) begin
            case (byte_cnt)
                2'd0: i_lo <= i_byte;
                2'd1: i_hi <= i_byte;
                2'd2: q_lo <= i_byte;
                default: begin
                    o_sample.i <= quantize({i_hi, i_lo});
                    o_sample.q <= quantize({i_byte, q_lo});
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- channel_fir.sv
`default_nettype none

`include "fm_defs.svh"

module channel_fir (
    input  logic               clock,
    input  logic               i_rst_n,
    input  fm_sample_pkg::iq_t i_sample,
    input  logic               i_sample_wr_en,
    output logic               o_busy,
    output fm_sample_pkg::iq_t o_result,
    output logic               o_wr_en,
    input  logic               i_out_full
);

    localparam int unsigned TAP_BITS = $clog2(`FM_FIR_TAPS);
    localparam logic [TAP_BITS-1:0] LAST_TAP = TAP_BITS'(`FM_FIR_TAPS - 1);

    fm_sample_pkg::fir_state_t state;
    fm_sample_pkg::iq_t        history [`FM_FIR_TAPS];
    logic [TAP_BITS-1:0]       tap_cnt;
    fm_sample_pkg::acc_t       acc_i;
    fm_sample_pkg::acc_t       acc_q;
    fm_sample_pkg::acc_t       prod_i;
    fm_sample_pkg::acc_t       prod_q;
    fm_sample_pkg::acc_t       acc_i_shr;
    fm_sample_pkg::acc_t       acc_q_shr;
    fm_coeff_pkg::coeff_t      tap_coeff;

    assign o_busy  = (state != fm_sample_pkg::FIR_IDLE);
    assign o_wr_en = (state == fm_sample_pkg::FIR_WRITE) && !i_out_full;

    // One tap per cycle, both rails share the coefficient
    assign tap_coeff = fm_coeff_pkg::CHANNEL_COEFFS[tap_cnt];
    assign prod_i = fm_sample_pkg::acc_t'(history[tap_cnt].i)
                  * fm_sample_pkg::acc_t'(tap_coeff);
    assign prod_q = fm_sample_pkg::acc_t'(history[tap_cnt].q)
                  * fm_sample_pkg::acc_t'(tap_coeff);

    // Dequantize
    assign acc_i_shr  = acc_i >>> `FM_QUANT_BITS;
    assign acc_q_shr  = acc_q >>> `FM_QUANT_BITS;
    assign o_result.i = acc_i_shr[`FM_DATA_BITS-1:0];
    assign o_result.q = acc_q_shr[`FM_DATA_BITS-1:0];

    always_ff @(posedge clock) begin
        if (!i_rst_n) begin
            state   <= fm_sample_pkg::FIR_IDLE;
            tap_cnt <= '0;
            for (int k = 0; k < `FM_FIR_TAPS; k++) begin
                history[k] <= '0;
            end
        end else begin
            case (state)
                fm_sample_pkg::FIR_IDLE: begin
                    if (i_sample_wr_en) begin
                        history[0] <= i_sample;
                        for (int k = 1; k < `FM_FIR_TAPS; k++) begin
                            history[k] <= history[k-1];
                        end
                        tap_cnt <= '0;
                        state   <= fm_sample_pkg::FIR_ACCUMULATE;
                    end
                end
                fm_sample_pkg::FIR_ACCUMULATE: begin
                    tap_cnt <= tap_cnt + 1'b1;
                    if (tap_cnt == LAST_TAP) begin
                        state <= fm_sample_pkg::FIR_WRITE;
                    end
                end
                fm_sample_pkg::FIR_WRITE: begin
                    // Hold here under back-pressure
                    if (!i_out_full) begin
                        state <= fm_sample_pkg::FIR_IDLE;
                    end
                end
                default: state <= fm_sample_pkg::FIR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == fm_sample_pkg::FIR_IDLE && i_sample_wr_en) begin
            acc_i <= '0;
            acc_q <= '0;
        end else if (state == fm_sample_pkg::FIR_ACCUMULATE) begin
            acc_i <= acc_i + prod_i;
            acc_q <= acc_q + prod_q;
        end
    end

endmodule

`default_nettype wire

//--- fm_frontend_top.sv
`default_nettype none

`include "fm_defs.svh"

module fm_frontend_top (
    input  logic                 clock,
    input  logic                 i_rst_n,
    input  logic                 i_in_wr_en,
    input  fm_sample_pkg::byte_t i_in_din,
    output logic                 o_in_full,
    input  logic                 i_out_rd_en,
    output fm_sample_pkg::iq_t   o_out_iq,
    output logic                 o_out_empty
);

    fm_sample_pkg::byte_t in_dout;
    logic                 in_empty;
    logic                 in_rd_en;
    fm_sample_pkg::iq_t   dec_sample;
    logic                 dec_wr_en;
    logic                 fir_busy;
    fm_sample_pkg::iq_t   fir_result;
    logic                 fir_wr_en;
    logic                 out_full;

    sample_fifo #(
        .WIDTH($bits(fm_sample_pkg::byte_t)),
        .DEPTH(`FM_IN_FIFO_DEPTH)
    ) in_fifo_inst (
        .clock(clock),
        .i_rst_n(i_rst_n),
        .i_wr_en(i_in_wr_en),
        .i_din(i_in_din),
        .o_full(o_in_full),
        .i_rd_en(in_rd_en),
        .o_dout(in_dout),
        .o_empty(in_empty)
    );

    iq_decode iq_decode_inst (
        .clock(clock),
        .i_rst_n(i_rst_n),
        .i_byte(in_dout),
        .i_byte_empty(in_empty),
        .o_byte_rd_en(in_rd_en),
        .i_busy(fir_busy),
        .o_sample(dec_sample),
        .o_sample_wr_en(dec_wr_en)
    );

    channel_fir channel_fir_inst (
        .clock(clock),
        .i_rst_n(i_rst_n),
        .i_sample(dec_sample),
        .i_sample_wr_en(dec_wr_en),
        .o_busy(fir_busy),
        .o_result(fir_result),
        .o_wr_en(fir_wr_en),
        .i_out_full(out_full)
    );

    // Filtered I/Q pairs
    sample_fifo #(
        .WIDTH($bits(fm_sample_pkg::iq_t)),
        .DEPTH(`FM_OUT_FIFO_DEPTH)
    ) out_fifo_inst (
        .clock(clock),
        .i_rst_n(i_rst_n),
        .i_wr_en(fir_wr_en),
        .i_din(fir_result),
        .o_full(out_full),
        .i_rd_en(i_out_rd_en),
        .o_dout(o_out_iq),
        .o_empty(o_out_empty)
    );

endmodule

`default_nettype wire

//--- tb_checker.sv
`default_nettype none

module tb_checker #(
    parameter int NAME_BITS = 160
) (
    input  logic                 clock,
    input  logic                 i_rst_n,
    input  logic                 i_out_empty,
    input  fm_sample_pkg::iq_t   i_out_iq,
    input  logic                 i_in_full,
    input  logic                 i_stall,
    input  logic                 i_exp_stb,
    input  fm_sample_pkg::iq_t   i_exp_iq,
    input  logic [NAME_BITS-1:0] i_exp_name,
    output logic                 o_rd_en = 1'b0,
    output int                   o_pending = 0,
    output int                   o_errors = 0,
    output int                   o_checked = 0
);
    timeunit 1ns;
    timeprecision 1ps;

    fm_sample_pkg::iq_t   exp_q [$];
    logic [NAME_BITS-1:0] name_q [$];
    fm_sample_pkg::iq_t   exp_iq;
    logic [NAME_BITS-1:0] exp_name;
    logic                 reset_seen = 1'b0;
    logic                 stall_d = 1'b0;

    // Pop whenever a pair is showing, except in stall windows
    always @(negedge clock) begin
        o_rd_en <= i_rst_n && !i_out_empty && !i_stall;
    end

    always @(posedge clock) begin
        if (i_rst_n && !reset_seen) begin
            reset_seen = 1'b1;
            if (!i_out_empty || i_in_full) begin
                $display("MISMATCH reset_state expected empty=1 full=0 actual empty=%0b full=%0b",
                         i_out_empty, i_in_full);
                o_errors++;
            end
        end
        // A long read stall backs the whole path up into the input FIFO
        if (stall_d && !i_stall && !i_in_full) begin
            $display("Input FIFO was not full when the read stall ended");
            o_errors++;
        end
        stall_d = i_stall;
        if (i_exp_stb) begin
            exp_q.push_back(i_exp_iq);
            name_q.push_back(i_exp_name);
        end
        // The pair popped on this edge
        if (o_rd_en) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected extra output i=%h q=%h after all expected pairs were seen",
                         i_out_iq.i, i_out_iq.q);
                o_errors++;
            end else begin
                exp_iq   = exp_q.pop_front();
                exp_name = name_q.pop_front();
                o_checked++;
                if (i_out_iq !== exp_iq) begin
                    $display("MISMATCH %0s expected i=%h q=%h actual i=%h q=%h", exp_name,
                             exp_iq.i, exp_iq.q, i_out_iq.i, i_out_iq.q);
                    o_errors++;
                end
            end
        end
        o_pending = exp_q.size();
    end

endmodule

`default_nettype wire

//--- tb_fm_frontend.sv
`default_nettype none

module tb_fm_frontend;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NAME_BITS = 160;

    logic                 clock = 1'b0;
    logic                 rst_n = 1'b0;
    logic                 in_wr_en = 1'b0;
    fm_sample_pkg::byte_t in_din = '0;
    logic                 in_full;
    logic                 out_rd_en;
    fm_sample_pkg::iq_t   out_iq;
    logic                 out_empty;
    logic                 exp_stb = 1'b0;
    fm_sample_pkg::iq_t   exp_iq = '0;
    logic [NAME_BITS-1:0] exp_name = '0;
    logic                 stall = 1'b0;
    logic                 loaded = 1'b0;
    int                   cycle = 0;
    int                   stall_end = 0;
    int                   limit_cycles = 0;
    int                   pending;
    int                   errors;
    int                   checked;

    fm_sample_pkg::byte_t byte_q [$];
    int                   hold_q [$];
    fm_sample_pkg::iq_t   pair_q [$];
    logic [NAME_BITS-1:0] pname_q [$];

    always #20 clock = ~clock;

    // Read stalls are counted in clock cycles
    always @(posedge clock) begin
        cycle <= cycle + 1;
        stall <= (cycle < stall_end);
    end

    fm_frontend_top fm_frontend_top_inst (
        .clock(clock),
        .i_rst_n(rst_n),
        .i_in_wr_en(in_wr_en),
        .i_in_din(in_din),
        .o_in_full(in_full),
        .i_out_rd_en(out_rd_en),
        .o_out_iq(out_iq),
        .o_out_empty(out_empty)
    );

    tb_checker #(
        .NAME_BITS(NAME_BITS)
    ) checker_inst (
        .clock(clock),
        .i_rst_n(rst_n),
        .i_out_empty(out_empty),
        .i_out_iq(out_iq),
        .i_in_full(in_full),
        .i_stall(stall),
        .i_exp_stb(exp_stb),
        .i_exp_iq(exp_iq),
        .i_exp_name(exp_name),
        .o_rd_en(out_rd_en),
        .o_pending(pending),
        .o_errors(errors),
        .o_checked(checked)
    );

    task automatic load_tests(output bit ok);
        int                   fd;
        int                   n;
        int                   rep;
        int                   hold;
        string                line;
        string                tag;
        logic [NAME_BITS-1:0] name;
        logic [15:0]          si;
        logic [15:0]          sq;
        logic [31:0]          word;
        logic [31:0]          ev [8];
        name = '0;
        fd = $fopen("frontend_tests.txt", "r");
        ok = (fd != 0);
        while (ok && !$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 1 && line[0] != "#") begin
                n = $sscanf(line, "%s", tag);
                if (tag == "T") begin
                    n = $sscanf(line, "%s %s", tag, name);
                end else if (tag == "S") begin
                    hold = 0;
                    n = $sscanf(line, "%s %h %h %d %d", tag, si, sq, rep, hold);
                    word = {sq, si};
                    // Each sample goes out as I low, I high, Q low, Q high
                    for (int r = 0; r < rep; r++) begin
                        for (int b = 0; b < 4; b++) begin
                            byte_q.push_back(word[8*b +: 8]);
                            hold_q.push_back((r == 0 && b == 0) ? hold : 0);
                        end
                    end
                end else if (tag == "E") begin
                    n = $sscanf(line, "%s %h %h %h %h %h %h %h %h", tag, ev[0], ev[1],
                                ev[2], ev[3], ev[4], ev[5], ev[6], ev[7]);
                    for (int p = 0; p < (n - 1) / 2; p++) begin
                        pair_q.push_back({ev[2*p], ev[2*p+1]});
                        pname_q.push_back(name);
                    end
                end
            end
        end
        if (ok) begin
            $fclose(fd);
        end
        ok = ok && (pair_q.size() > 0) && (byte_q.size() > 0);
    endtask

    task automatic run_tests();
        int hold;
        repeat (2) @(negedge clock);
        rst_n = 1'b1;
        // Checker gets every expected pair before the first byte
        while (pair_q.size() > 0) begin
            exp_stb  = 1'b1;
            exp_iq   = pair_q.pop_front();
            exp_name = pname_q.pop_front();
            @(negedge clock);
        end
        exp_stb = 1'b0;
        while (byte_q.size() > 0) begin
            hold = hold_q.pop_front();
            if (hold > 0) begin
                stall_end = cycle + hold;
            end
            in_wr_en = 1'b0;
            while (in_full) begin
                @(negedge clock);
            end
            in_wr_en = 1'b1;
            in_din   = byte_q.pop_front();
            @(negedge clock);
        end
        in_wr_en = 1'b0;
        while (pending > 0) begin
            @(negedge clock);
        end
        // Leave time for a stray extra output
        repeat (50) @(negedge clock);
    endtask

    initial begin
        bit ok;
        load_tests(ok);
        limit_cycles = 40 * byte_q.size() + 200;
        loaded = 1'b1;
        if (!ok) begin
            $display("Could not read test data from frontend_tests.txt");
            $display("Finished with errors");
        end else begin
            run_tests();
            $display("Checked %0d outputs with %0d errors and %0d missing",
                     checked, errors, pending);
            if (errors == 0 && pending == 0) begin
                $display("Finished with no errors");
            end else begin
                $display("Finished with errors");
            end
        end
        $finish;
    end

    initial begin
        wait (loaded);
        repeat (limit_cycles) @(posedge clock);
        $display("Timeout after %0d cycles with %0d expected pairs still missing",
                 limit_cycles, pending);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- frontend_tests.txt
# Each line is T and a test name, S and an input sample, or E and expected output pairs
# S takes I and Q as 16-bit hex, a repeat count and optional read stall cycles; E takes up to four I Q pairs
T impulse_i
S 0001 0000 1
S 0000 0000 19
E 00000001 00000000 00000008 00000000 fffffff3 00000000 00000009 00000000
E 0000000b 00000000 ffffffd3 00000000 00000045 00000000 ffffffd3 00000000
E ffffff31 00000000 00000257 00000000 00000257 00000000 ffffff31 00000000
E ffffffd3 00000000 00000045 00000000 ffffffd3 00000000 0000000b 00000000
E 00000009 00000000 fffffff3 00000000 00000008 00000000 00000001 00000000
T sign_q_stall
S 0000 ffff 1 600
S 0000 0000 23
E 00000000 ffffffff 00000000 fffffff8 00000000 0000000d 00000000 fffffff7
E 00000000 fffffff5 00000000 0000002d 00000000 ffffffbb 00000000 0000002d
E 00000000 000000cf 00000000 fffffda9 00000000 fffffda9 00000000 000000cf
E 00000000 0000002d 00000000 ffffffbb 00000000 0000002d 00000000 fffffff5
E 00000000 fffffff7 00000000 0000000d 00000000 fffffff8 00000000 ffffffff
E 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
T mixed
S 0002 fffd 1
S ffff 0005 1
S 0004 0000 1
S 0000 0001 1
E 00000002 fffffffd 0000000f ffffffed ffffffe2 0000004f 0000003f ffffffa5

//--- all.f
+incdir+.
fm_sample_pkg.sv
fm_coeff_pkg.sv
sample_fifo.sv
iq_decode.sv
channel_fir.sv
fm_frontend_top.sv
tb_checker.sv
tb_fm_frontend.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_fm_frontend
LOG ?= sim.log

BUILD_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --timescale 1ns/1ps -f all.f --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
